/* design/csr_pkg.sv */
/*
 * CSR package: addresses, cause codes, privilege levels, bit positions
 * and the command and trap structs shared by the machine-mode CSR unit
 */
`default_nettype none

package csr_pkg;

  typedef enum logic [11:0] {
    csr_mstatus  = 12'h300,
    csr_misa     = 12'h301,
    csr_mie      = 12'h304,
    csr_mtvec    = 12'h305,
    csr_mscratch = 12'h340,
    csr_mepc     = 12'h341,
    csr_mcause   = 12'h342,
    csr_mtval    = 12'h343,
    csr_mip      = 12'h344
  } csr_addr_e;

  typedef enum logic [1:0] {
    priv_user    = 2'd0,
    priv_machine = 2'd3
  } priv_e;

  // Interrupt and exception codes share one encoding space
  typedef enum logic [3:0] {
    cause_illegal = 4'd2,
    cause_msi     = 4'd3,
    cause_mti     = 4'd7,
    cause_ecall_u = 4'd8,
    cause_mei     = 4'd11
  } cause_code_e;

  // Machine ecall reuses code 11 on the exception side
  localparam cause_code_e cause_ecall_m = cause_code_e'(4'd11);

  // mstatus fields
  localparam int unsigned mie_bit  = 3;
  localparam int unsigned mpie_bit = 7;
  localparam int unsigned mpp_lsb  = 11;

  // mie and mip fields
  localparam int unsigned msi_bit = 3;
  localparam int unsigned mti_bit = 7;
  localparam int unsigned mei_bit = 11;

  typedef struct packed {
    logic      write_en;
    csr_addr_e addr;
    logic      mret;
    logic      ecall;
    logic      illegal_instruction;
  } csr_cmd_t;

  typedef struct packed {
    logic        taken;
    logic        is_interrupt;
    cause_code_e code;
  } trap_t;

  typedef struct packed {
    logic software;
    logic timer;
    logic external;
  } irq_t;

endpackage

`default_nettype wire

/* design/csr_trap_ctrl.sv */
/*
 * Trap control: picks the highest priority interrupt or exception,
 * computes the trap target and cancels the CSR command on a trap
 */
`timescale 1ns/1ps
`default_nettype none

module csr_trap_ctrl
  import csr_pkg::*;
#(
  parameter int xlen = 32
) (
  input  csr_cmd_t              cmd,
  input  irq_t                  irq_pending,
  input  logic     [xlen-1:0]   mie_value,
  input  logic     [xlen-1:0]   mtvec_value,
  input  logic     [xlen-1:0]   mstatus_value,
  input  priv_e                 priv,
  output trap_t                 trap,
  output logic                  trap_taken,
  output logic     [xlen-1:0]   trap_addr,
  output logic                  mret_commit,
  output logic                  write_commit
);

  logic            global_enable;
  irq_t            irq_active;
  logic [xlen-1:0] vector_base;
  logic [xlen-1:0] vector_offset;

  // User mode always takes machine interrupts
  assign global_enable = (priv == priv_user) || mstatus_value[mie_bit];

  assign irq_active.software = irq_pending.software & mie_value[msi_bit] & global_enable;
  assign irq_active.timer    = irq_pending.timer & mie_value[mti_bit] & global_enable;
  assign irq_active.external = irq_pending.external & mie_value[mei_bit] & global_enable;

  // Interrupts first, then illegal instruction, then ecall
  always_comb begin
    trap = '0;
    if (irq_active.external) begin
      trap.taken        = 1'b1;
      trap.is_interrupt = 1'b1;
      trap.code         = cause_mei;
    end else if (irq_active.timer) begin
      trap.taken        = 1'b1;
      trap.is_interrupt = 1'b1;
      trap.code         = cause_mti;
    end else if (irq_active.software) begin
      trap.taken        = 1'b1;
      trap.is_interrupt = 1'b1;
      trap.code         = cause_msi;
    end else if (cmd.illegal_instruction) begin
      trap.taken = 1'b1;
      trap.code  = cause_illegal;
    end else if (cmd.ecall) begin
      trap.taken = 1'b1;
      trap.code  = (priv == priv_user) ? cause_ecall_u : cause_ecall_m;
    end
  end

  assign trap_taken = trap.taken;

  // Vectored mode only applies to interrupts
  assign vector_base   = {mtvec_value[xlen-1:2], 2'b00};
  assign vector_offset = xlen'(trap.code) << 2;
  assign trap_addr     = (mtvec_value[0] && trap.is_interrupt) ? vector_base + vector_offset
                                                               : vector_base;

  // A trap cancels the command; mret also blocks a write
  assign mret_commit  = cmd.mret & ~trap.taken;
  assign write_commit = cmd.write_en & ~cmd.mret & ~trap.taken;

endmodule

`default_nettype wire

/* design/csr_status.sv */
/*
 * mstatus fields and the current privilege level, updated by traps,
 * mret and CSR writes
 */
`timescale 1ns/1ps
`default_nettype none

module csr_status
  import csr_pkg::*;
#(
  parameter int xlen = 32
) (
  input  logic                  clock,
  input  logic                  reset,
  input  trap_t                 trap,
  input  logic                  mret_commit,
  input  logic                  write_commit,
  input  csr_addr_e             addr,
  input  logic     [xlen-1:0]   wr_data,
  output logic     [xlen-1:0]   mstatus_value,
  output priv_e                 priv
);

  logic  mie_q;
  logic  mpie_q;
  priv_e mpp_q;
  logic  [1:0] mpp_wr;

  assign mpp_wr = wr_data[mpp_lsb +: 2];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mie_q  <= 1'b0;
      mpie_q <= 1'b0;
      mpp_q  <= priv_user;
      priv   <= priv_machine;
    end else if (trap.taken) begin
      mpie_q <= mie_q;
      mie_q  <= 1'b0;
      mpp_q  <= priv;
      priv   <= priv_machine;
    end else if (mret_commit) begin
      priv   <= mpp_q;
      mie_q  <= mpie_q;
      mpie_q <= 1'b1;
      mpp_q  <= priv_user;
    end else if (write_commit && addr == csr_mstatus) begin
      mie_q  <= wr_data[mie_bit];
      mpie_q <= wr_data[mpie_bit];
      // Only user and machine are legal for MPP
      if (mpp_wr == 2'b00 || mpp_wr == 2'b11) begin
        mpp_q <= priv_e'(mpp_wr);
      end
    end
  end

  always_comb begin
    mstatus_value                 = '0;
    mstatus_value[mie_bit]        = mie_q;
    mstatus_value[mpie_bit]       = mpie_q;
    mstatus_value[mpp_lsb +: 2]   = mpp_q;
  end

endmodule

`default_nettype wire

/* design/csr_regfile.sv */
/*
 * Machine CSR storage: mie, mtvec, mscratch, mepc, mcause and mtval,
 * the mip and misa views and the combinational read port
 */
`timescale 1ns/1ps
`default_nettype none

module csr_regfile
  import csr_pkg::*;
#(
  parameter int xlen = 32
) (
  input  logic                  clock,
  input  logic                  reset,
  input  csr_addr_e             addr,
  input  logic                  write_commit,
  input  logic     [xlen-1:0]   wr_data,
  input  trap_t                 trap,
  input  logic     [xlen-1:0]   pc,
  input  logic     [31:0]       instruction,
  input  logic                  msip,
  input  logic                  external_interrupt,
  input  logic     [63:0]       mtime,
  input  logic     [63:0]       mtimecmp,
  input  logic     [xlen-1:0]   mstatus_value,
  output logic     [xlen-1:0]   rd_data,
  output logic                  addr_exception,
  output irq_t                  irq_pending,
  output logic     [xlen-1:0]   mie_value,
  output logic     [xlen-1:0]   mtvec_value,
  output logic     [xlen-1:0]   mepc
);

  localparam logic [xlen-1:0] mie_mask =
    xlen'((1 << msi_bit) | (1 << mti_bit) | (1 << mei_bit));

  logic [xlen-1:0] mscratch;
  logic [xlen-1:0] mcause;
  logic [xlen-1:0] mtval;
  logic [xlen-1:0] mip;
  logic [xlen-1:0] misa;
  logic            cause_legal;

  // Only codes this core can raise may be written to mcause
  function automatic logic check_cause(input logic [xlen-1:0] value);
    logic            interrupt;
    logic [xlen-2:0] code;
    interrupt = value[xlen-1];
    code      = value[xlen-2:0];
    if (interrupt) begin
      return (code == 3) || (code == 7) || (code == 11);
    end
    return (code == 2) || (code == 8) || (code == 11);
  endfunction

  assign cause_legal = check_cause(wr_data);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mie_value <= '0;
    end else if (write_commit && addr == csr_mie) begin
      mie_value <= wr_data & mie_mask;
    end
  end

  // Bit 1 of mtvec is reserved
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mtvec_value <= '0;
    end else if (write_commit && addr == csr_mtvec) begin
      mtvec_value <= {wr_data[xlen-1:2], 1'b0, wr_data[0]};
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mscratch <= '0;
    end else if (write_commit && addr == csr_mscratch) begin
      mscratch <= wr_data;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mepc <= '0;
    end else if (trap.taken) begin
      mepc <= pc;
    end else if (write_commit && addr == csr_mepc) begin
      mepc <= {wr_data[xlen-1:2], 2'b00};
    end
  end

  // Interrupt flag sits in the top bit
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mcause <= '0;
    end else if (trap.taken) begin
      mcause <= {trap.is_interrupt, (xlen-1)'(trap.code)};
    end else if (write_commit && addr == csr_mcause && cause_legal) begin
      mcause <= wr_data;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mtval <= '0;
    end else if (trap.taken && !trap.is_interrupt && trap.code == cause_illegal) begin
      mtval <= xlen'(instruction);
    end else if (write_commit && addr == csr_mtval) begin
      mtval <= wr_data;
    end
  end

  assign irq_pending.software = msip;
  assign irq_pending.timer    = mtime >= mtimecmp;
  assign irq_pending.external = external_interrupt;

  always_comb begin
    mip          = '0;
    mip[msi_bit] = irq_pending.software;
    mip[mti_bit] = irq_pending.timer;
    mip[mei_bit] = irq_pending.external;
  end

  // MXL on top, extensions I and U
  always_comb begin
    misa                  = '0;
    misa[xlen-1:xlen-2]   = 2'(xlen / 32);
    misa[8]               = 1'b1;
    misa[20]              = 1'b1;
  end

  always_comb begin
    rd_data        = '0;
    addr_exception = 1'b0;
    case (addr)
      csr_mstatus:  rd_data = mstatus_value;
      csr_misa:     rd_data = misa;
      csr_mie:      rd_data = mie_value;
      csr_mtvec:    rd_data = mtvec_value;
      csr_mscratch: rd_data = mscratch;
      csr_mepc:     rd_data = mepc;
      csr_mcause:   rd_data = mcause;
      csr_mtval:    rd_data = mtval;
      csr_mip:      rd_data = mip;
      default:      addr_exception = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* design/csr_unit.sv */
/*
 * Machine-mode CSR unit: trap control, status and register file
 */
`timescale 1ns/1ps
`default_nettype none

module csr_unit
  import csr_pkg::*;
#(
  parameter int xlen = 32
) (
  input  logic                  clock,
  input  logic                  reset,
  input  csr_cmd_t              cmd,
  input  logic     [xlen-1:0]   wr_data,
  input  logic     [xlen-1:0]   pc,
  input  logic     [31:0]       instruction,
  input  logic                  msip,
  input  logic                  external_interrupt,
  input  logic     [63:0]       mtime,
  input  logic     [63:0]       mtimecmp,
  output logic     [xlen-1:0]   rd_data,
  output logic                  addr_exception,
  output logic                  trap_taken,
  output logic     [xlen-1:0]   trap_addr,
  output logic     [xlen-1:0]   mepc,
  output priv_e                 priv
);

  trap_t           trap;
  irq_t            irq_pending;
  logic [xlen-1:0] mie_value;
  logic [xlen-1:0] mtvec_value;
  logic [xlen-1:0] mstatus_value;
  logic            mret_commit;
  logic            write_commit;

  csr_trap_ctrl #(.xlen(xlen)) trap_ctrl_i (
    .cmd           (cmd),
    .irq_pending   (irq_pending),
    .mie_value     (mie_value),
    .mtvec_value   (mtvec_value),
    .mstatus_value (mstatus_value),
    .priv          (priv),
    .trap          (trap),
    .trap_taken    (trap_taken),
    .trap_addr     (trap_addr),
    .mret_commit   (mret_commit),
    .write_commit  (write_commit)
  );

  csr_status #(.xlen(xlen)) status_i (
    .clock         (clock),
    .reset         (reset),
    .trap          (trap),
    .mret_commit   (mret_commit),
    .write_commit  (write_commit),
    .addr          (cmd.addr),
    .wr_data       (wr_data),
    .mstatus_value (mstatus_value),
    .priv          (priv)
  );

  csr_regfile #(.xlen(xlen)) regfile_i (
    .clock              (clock),
    .reset              (reset),
    .addr               (cmd.addr),
    .write_commit       (write_commit),
    .wr_data            (wr_data),
    .trap               (trap),
    .pc                 (pc),
    .instruction        (instruction),
    .msip               (msip),
    .external_interrupt (external_interrupt),
    .mtime              (mtime),
    .mtimecmp           (mtimecmp),
    .mstatus_value      (mstatus_value),
    .rd_data            (rd_data),
    .addr_exception     (addr_exception),
    .irq_pending        (irq_pending),
    .mie_value          (mie_value),
    .mtvec_value        (mtvec_value),
    .mepc               (mepc)
  );

endmodule

`default_nettype wire

/* tb/csr_clock_gen.sv */
/*
 * Clock and reset source for the CSR unit testbench
 */
`timescale 1ns/1ps
`default_nettype none

module csr_clock_gen (
  output logic clock,
  output logic reset
);

  // 20 ns period
  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Reset held for 8 clock cycles
  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

/* tb/csr_checker.sv */
/*
 * CSR unit checker: shadow model of the machine CSRs, reference outputs,
 * comparison of every DUT output on the falling edge and per-test reports
 */
`timescale 1ns/1ps
`default_nettype none

module csr_checker
  import csr_pkg::*;
#(
  parameter int xlen = 32
) (
  input  logic            clock,
  input  logic            reset,
  input  logic [7:0]      test_id,
  input  csr_cmd_t        cmd,
  input  logic [xlen-1:0] wr_data,
  input  logic [xlen-1:0] pc,
  input  logic [31:0]     instruction,
  input  logic            msip,
  input  logic            external_interrupt,
  input  logic [63:0]     mtime,
  input  logic [63:0]     mtimecmp,
  input  logic [xlen-1:0] rd_data,
  input  logic            addr_exception,
  input  logic            trap_taken,
  input  logic [xlen-1:0] trap_addr,
  input  logic [xlen-1:0] mepc,
  input  priv_e           priv,
  output int              error_count,
  output int              check_count
);

  typedef struct packed {
    logic [xlen-1:0] rd_data;
    logic            addr_exception;
    logic            trap_taken;
    logic [xlen-1:0] trap_addr;
    priv_e           priv;
  } expect_t;

  // Shadow state as the DUT holds it during the current cycle
  logic            s_mie;
  logic            s_mpie;
  priv_e           s_mpp;
  priv_e           s_priv;
  logic [xlen-1:0] s_mie_en;
  logic [xlen-1:0] s_mtvec;
  logic [xlen-1:0] s_mscratch;
  logic [xlen-1:0] s_mepc;
  logic [xlen-1:0] s_mcause;
  logic [xlen-1:0] s_mtval;
  logic [7:0]      current_test;
  int              test_errors;
  int              test_checks;

  function automatic trap_t decide_trap();
    trap_t t;
    logic  enable;
    t      = '0;
    enable = (s_priv == priv_user) || s_mie;
    if (enable && external_interrupt && s_mie_en[mei_bit]) begin
      t = '{1'b1, 1'b1, cause_mei};
    end else if (enable && (mtime >= mtimecmp) && s_mie_en[mti_bit]) begin
      t = '{1'b1, 1'b1, cause_mti};
    end else if (enable && msip && s_mie_en[msi_bit]) begin
      t = '{1'b1, 1'b1, cause_msi};
    end else if (cmd.illegal_instruction) begin
      t = '{1'b1, 1'b0, cause_illegal};
    end else if (cmd.ecall) begin
      t = '{1'b1, 1'b0, (s_priv == priv_user) ? cause_ecall_u : cause_ecall_m};
    end
    return t;
  endfunction

  function automatic expect_t reference_outputs();
    expect_t         e;
    trap_t           t;
    logic [xlen-1:0] base;
    t = decide_trap();
    e = '0;
    case (cmd.addr)
      csr_mstatus: begin
        e.rd_data[mie_bit]      = s_mie;
        e.rd_data[mpie_bit]     = s_mpie;
        e.rd_data[mpp_lsb +: 2] = s_mpp;
      end
      csr_misa: begin
        e.rd_data             = xlen'(32'h0010_0100);
        e.rd_data[xlen-1 -: 2] = 2'(xlen / 32);
      end
      csr_mie:      e.rd_data = s_mie_en;
      csr_mtvec:    e.rd_data = s_mtvec;
      csr_mscratch: e.rd_data = s_mscratch;
      csr_mepc:     e.rd_data = s_mepc;
      csr_mcause:   e.rd_data = s_mcause;
      csr_mtval:    e.rd_data = s_mtval;
      csr_mip: begin
        e.rd_data[msi_bit] = msip;
        e.rd_data[mti_bit] = mtime >= mtimecmp;
        e.rd_data[mei_bit] = external_interrupt;
      end
      default: e.addr_exception = 1'b1;
    endcase
    base         = s_mtvec & ~xlen'(3);
    e.trap_taken = t.taken;
    e.trap_addr  = (s_mtvec[0] && t.is_interrupt) ? base + 4 * xlen'(t.code) : base;
    e.priv       = s_priv;
    return e;
  endfunction

  // Moves the shadow state across the coming rising edge
  task automatic update_shadow();
    trap_t           t;
    logic [xlen-1:0] d;
    t = decide_trap();
    d = wr_data;
    if (t.taken) begin
      s_mpie   = s_mie;
      s_mie    = 1'b0;
      s_mpp    = s_priv;
      s_priv   = priv_machine;
      s_mepc   = pc;
      s_mcause = {t.is_interrupt, (xlen-1)'(t.code)};
      if (!t.is_interrupt && t.code == cause_illegal) begin
        s_mtval = xlen'(instruction);
      end
    end else if (cmd.mret) begin
      s_priv = s_mpp;
      s_mie  = s_mpie;
      s_mpie = 1'b1;
      s_mpp  = priv_user;
    end else if (cmd.write_en) begin
      case (cmd.addr)
        csr_mstatus: begin
          s_mie  = d[mie_bit];
          s_mpie = d[mpie_bit];
          if (d[mpp_lsb +: 2] inside {2'd0, 2'd3}) begin
            s_mpp = priv_e'(d[mpp_lsb +: 2]);
          end
        end
        csr_mie:      s_mie_en = d & xlen'(32'h888);
        csr_mtvec:    s_mtvec = d & ~xlen'(2);
        csr_mscratch: s_mscratch = d;
        csr_mepc:     s_mepc = d & ~xlen'(3);
        csr_mcause: begin
          if (d[xlen-1] ? (d[xlen-2:0] inside {3, 7, 11}) : (d[xlen-2:0] inside {2, 8, 11})) begin
            s_mcause = d;
          end
        end
        csr_mtval:    s_mtval = d;
        default:      ;
      endcase
    end
  endtask

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    check_count++;
    test_checks++;
    if (expected !== actual) begin
      error_count++;
      test_errors++;
      $display("FAILED %s in test %0d at %0t: expected 0x%h, got 0x%h",
               name, current_test, $time, expected, actual);
    end
  endtask

  always @(negedge clock) begin
    expect_t e;
    if (reset) begin
      s_mie        = 1'b0;
      s_mpie       = 1'b0;
      s_mpp        = priv_user;
      s_priv       = priv_machine;
      s_mie_en     = '0;
      s_mtvec      = '0;
      s_mscratch   = '0;
      s_mepc       = '0;
      s_mcause     = '0;
      s_mtval      = '0;
      current_test = '0;
      test_errors  = 0;
      test_checks  = 0;
      error_count  = 0;
      check_count  = 0;
    end else begin
      if (test_id != current_test) begin
        if (current_test != 0) begin
          $display("test %0d finished: %0d checks, %0d errors",
                   current_test, test_checks, test_errors);
        end
        current_test = test_id;
        test_errors  = 0;
        test_checks  = 0;
      end
      e = reference_outputs();
      compare_value("rd_data", 64'(e.rd_data), 64'(rd_data));
      compare_value("addr_exception", 64'(e.addr_exception), 64'(addr_exception));
      compare_value("trap_taken", 64'(e.trap_taken), 64'(trap_taken));
      compare_value("priv", 64'(e.priv), 64'(priv));
      compare_value("mepc", 64'(s_mepc), 64'(mepc));
      if (e.trap_taken) begin
        compare_value("trap_addr", 64'(e.trap_addr), 64'(trap_addr));
      end
      update_shadow();
    end
  end

endmodule

`default_nettype wire

/* tb/csr_tb.sv */
/*
 * Testbench top for the machine-mode CSR unit: stimulus, watchdog
 * and the closing result
 */
`timescale 1ns/1ps
`default_nettype none

module csr_tb
  import csr_pkg::*;
;

  localparam int xlen            = 32;
  localparam int stimulus_cycles = 90;
  localparam int timeout_ns      = (stimulus_cycles + 8 + 30) * 20;

  logic            clock;
  logic            reset;
  csr_cmd_t        cmd;
  logic [xlen-1:0] wr_data;
  logic [xlen-1:0] pc;
  logic [31:0]     instruction;
  logic            msip;
  logic            external_interrupt;
  logic [63:0]     mtime;
  logic [63:0]     mtimecmp;
  logic [xlen-1:0] rd_data;
  logic            addr_exception;
  logic            trap_taken;
  logic [xlen-1:0] trap_addr;
  logic [xlen-1:0] mepc;
  priv_e           priv;
  logic [7:0]      test_id;
  int              error_count;
  int              check_count;
  logic [xlen-1:0] next_pc;
  logic [31:0]     next_instr;

  csr_clock_gen clock_gen_i (
    .clock (clock),
    .reset (reset)
  );

  csr_unit #(.xlen(xlen)) csr_unit_i (
    .clock              (clock),
    .reset              (reset),
    .cmd                (cmd),
    .wr_data            (wr_data),
    .pc                 (pc),
    .instruction        (instruction),
    .msip               (msip),
    .external_interrupt (external_interrupt),
    .mtime              (mtime),
    .mtimecmp           (mtimecmp),
    .rd_data            (rd_data),
    .addr_exception     (addr_exception),
    .trap_taken         (trap_taken),
    .trap_addr          (trap_addr),
    .mepc               (mepc),
    .priv               (priv)
  );

  csr_checker #(.xlen(xlen)) checker_i (
    .clock              (clock),
    .reset              (reset),
    .test_id            (test_id),
    .cmd                (cmd),
    .wr_data            (wr_data),
    .pc                 (pc),
    .instruction        (instruction),
    .msip               (msip),
    .external_interrupt (external_interrupt),
    .mtime              (mtime),
    .mtimecmp           (mtimecmp),
    .rd_data            (rd_data),
    .addr_exception     (addr_exception),
    .trap_taken         (trap_taken),
    .trap_addr          (trap_addr),
    .mepc               (mepc),
    .priv               (priv),
    .error_count        (error_count),
    .check_count        (check_count)
  );

  task automatic drive_cmd(input logic we, input csr_addr_e addr, input logic mret,
                           input logic ecall, input logic illegal,
                           input logic [xlen-1:0] data);
    csr_cmd_t c;
    c                     = '0;
    c.write_en            = we;
    c.addr                = addr;
    c.mret                = mret;
    c.ecall               = ecall;
    c.illegal_instruction = illegal;
    @(posedge clock);
    cmd         <= c;
    wr_data     <= data;
    pc          <= next_pc;
    instruction <= next_instr;
  endtask

  task automatic write_csr(input csr_addr_e addr, input logic [xlen-1:0] data);
    drive_cmd(1'b1, addr, 1'b0, 1'b0, 1'b0, data);
  endtask

  task automatic read_csr(input csr_addr_e addr);
    drive_cmd(1'b0, addr, 1'b0, 1'b0, 1'b0, '0);
  endtask

  // One idle cycle that opens the next test
  task automatic begin_test(input logic [7:0] id);
    drive_cmd(1'b0, csr_mstatus, 1'b0, 1'b0, 1'b0, '0);
    test_id <= id;
  endtask

  // Interrupt lines for one cycle, with mip on the read port
  task automatic set_interrupts(input logic sw, input logic ext, input logic tmr);
    drive_cmd(1'b0, csr_mip, 1'b0, 1'b0, 1'b0, '0);
    msip               <= sw;
    external_interrupt <= ext;
    mtime              <= tmr ? 64'd100 : 64'd0;
    mtimecmp           <= tmr ? 64'd50 : '1;
  endtask

  initial begin
    cmd                = '0;
    wr_data            = '0;
    pc                 = '0;
    instruction        = '0;
    msip               = 1'b0;
    external_interrupt = 1'b0;
    mtime              = '0;
    mtimecmp           = '1;
    test_id            = '0;
    next_pc            = '0;
    next_instr         = '0;
    void'($urandom(75));
    wait (reset == 1'b0);

    begin_test(8'd1);
    read_csr(csr_mstatus);
    read_csr(csr_mtvec);
    read_csr(csr_mepc);
    read_csr(csr_misa);

    begin_test(8'd2);
    repeat (4) begin
      write_csr(csr_mscratch, $urandom());
      read_csr(csr_mscratch);
    end
    // Reserved low bits set so that the clearing shows on the read
    write_csr(csr_mepc, $urandom() | 32'h3);
    read_csr(csr_mepc);
    write_csr(csr_mtvec, $urandom() | 32'h2);
    read_csr(csr_mtvec);
    write_csr(csr_mcause, 32'h8000_0007);
    read_csr(csr_mcause);
    write_csr(csr_mcause, 32'h0000_0005);
    read_csr(csr_mcause);
    read_csr(csr_addr_e'(12'h7c0));

    // Machine ecall with a write to mscratch in the same cycle
    begin_test(8'd3);
    write_csr(csr_mtvec, 32'h0000_1000);
    write_csr(csr_mstatus, 32'h0000_0008);
    next_pc = $urandom() & ~32'h3;
    drive_cmd(1'b1, csr_mscratch, 1'b0, 1'b1, 1'b0, 32'hdead_beef);
    read_csr(csr_mcause);
    read_csr(csr_mepc);
    read_csr(csr_mstatus);
    read_csr(csr_mscratch);

    begin_test(8'd4);
    write_csr(csr_mstatus, 32'h0000_0080);
    drive_cmd(1'b0, csr_mstatus, 1'b1, 1'b0, 1'b0, '0);
    next_pc = $urandom() & ~32'h3;
    drive_cmd(1'b0, csr_mstatus, 1'b0, 1'b1, 1'b0, '0);
    read_csr(csr_mcause);
    drive_cmd(1'b0, csr_mstatus, 1'b1, 1'b0, 1'b0, '0);
    next_pc    = $urandom() & ~32'h3;
    next_instr = $urandom();
    drive_cmd(1'b0, csr_mstatus, 1'b0, 1'b0, 1'b1, '0);
    read_csr(csr_mcause);
    read_csr(csr_mtval);

    begin_test(8'd5);
    write_csr(csr_mtvec, 32'h0000_2001);
    write_csr(csr_mie, 32'h0000_0fff);
    read_csr(csr_mie);
    write_csr(csr_mstatus, 32'h0000_0008);
    set_interrupts(1'b0, 1'b0, 1'b1);
    set_interrupts(1'b0, 1'b0, 1'b1);
    set_interrupts(1'b0, 1'b0, 1'b0);
    read_csr(csr_mcause);
    write_csr(csr_mstatus, 32'h0000_0008);
    set_interrupts(1'b0, 1'b1, 1'b1);
    set_interrupts(1'b0, 1'b0, 1'b0);
    read_csr(csr_mcause);
    // User mode with MIE clear, then machine mode with MIE clear
    write_csr(csr_mstatus, 32'h0000_0000);
    drive_cmd(1'b0, csr_mstatus, 1'b1, 1'b0, 1'b0, '0);
    set_interrupts(1'b1, 1'b0, 1'b0);
    set_interrupts(1'b1, 1'b0, 1'b0);
    set_interrupts(1'b0, 1'b0, 1'b0);
    read_csr(csr_mcause);

    begin_test(8'd6);
    @(posedge clock);
    @(posedge clock);
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("watchdog expired before the tests finished");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
design/csr_pkg.sv
design/csr_trap_ctrl.sv
design/csr_status.sv
design/csr_regfile.sv
design/csr_unit.sv
tb/csr_clock_gen.sv
tb/csr_checker.sv
tb/csr_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the CSR unit testbench with Verilator
rm -f sim.log
verilator --binary -f all.f --top-module csr_tb -o csr_tb_sim > sim.log 2>&1 &&
  ./obj_dir/csr_tb_sim >> sim.log 2>&1 ||
  echo "build or simulation error" >> sim.log
grep -q "TB FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "simulation did not pass, see sim.log"; exit 1; }
echo "simulation passed"
